/* hdl/shifter_cfg.svh */
`ifndef SHIFTER_CFG_SVH
`define SHIFTER_CFG_SVH

// datapath widths
`define SHP_DATA_W 32
`define SHP_REG_ADDR_W 4
`define SHP_AMOUNT_W 8

// register file layout
`define SHP_NUM_STORED_REGS 15
`define SHP_PC_REG 4'd15

// program counter behaviour
`define SHP_PC_STEP 32'd4
`define SHP_PC_READ_OFFSET 32'd8

// op field value for data processing
`define SHP_OP_DP 2'b00

`endif

/* hdl/shifter_pkg.sv */
`default_nettype none
`include "shifter_cfg.svh"

package shifter_pkg;

    typedef logic [`SHP_DATA_W-1:0] word_t;
    typedef logic [`SHP_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [1:0] {
        lsl = 2'b00,
        lsr = 2'b01,
        asr = 2'b10,
        ror = 2'b11
    } shift_kind_e;

    //////////////////////////////
    // instruction word views

    // register form, imm flag clear
    typedef struct packed {
        logic [3:0]  cond;
        logic [1:0]  op;
        logic        imm;
        logic [4:0]  spare;
        reg_addr_t   rn;
        reg_addr_t   rd;
        // rs lives in the top four bits when reg_amt is set
        logic [4:0]  shamt5;
        shift_kind_e kind;
        logic        reg_amt;
        reg_addr_t   rm;
    } dp_reg_t;

    // immediate form, imm flag set
    typedef struct packed {
        logic [3:0]  cond;
        logic [1:0]  op;
        logic        imm;
        // clear for imm8, set for imm12
        logic        size;
        logic [3:0]  spare;
        reg_addr_t   rn;
        reg_addr_t   rd;
        logic [11:0] imm12;
    } dp_imm_t;

    typedef union packed {
        dp_reg_t dp_reg;
        dp_imm_t dp_imm;
    } instr_u;

    //////////////////////////////
    // stage bundles

    // decode to execute
    typedef struct packed {
        logic                     valid;
        reg_addr_t                rd;
        word_t                    operand;
        logic [`SHP_AMOUNT_W-1:0] amount;
        shift_kind_e              kind;
        logic                     no_shift;
    } issue_t;

    // execute result, both forwarded and written back
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     value;
    } result_t;

endpackage

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none
`include "shifter_cfg.svh"

module reg_file (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire shifter_pkg::reg_addr_t ra_m,
    input  wire shifter_pkg::reg_addr_t ra_s,
    output shifter_pkg::word_t          rdata_m,
    output shifter_pkg::word_t          rdata_s,
    input  wire shifter_pkg::result_t   wb
);

    // r0 to r14, r15 is synthesized in decode
    shifter_pkg::word_t regs [`SHP_NUM_STORED_REGS];

    logic write_en;

    // writes to r15 are reported upstream but dropped here
    assign write_en = wb.valid && (wb.rd < `SHP_PC_REG);

    //////////////////////////////
    // write port

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `SHP_NUM_STORED_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[wb.rd] <= wb.value;
        end
    end

    //////////////////////////////
    // read ports

    // asynchronous, same-cycle data
    assign rdata_m = regs[ra_m];
    assign rdata_s = regs[ra_s];

endmodule

`default_nettype wire

/* hdl/operand_decode.sv */
`timescale 1ns/1ns
`default_nettype none
`include "shifter_cfg.svh"

module operand_decode (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 instr_valid,
    input  wire shifter_pkg::instr_u  instr,
    input  wire shifter_pkg::result_t fwd,
    output shifter_pkg::reg_addr_t    ra_m,
    output shifter_pkg::reg_addr_t    ra_s,
    input  wire shifter_pkg::word_t   rdata_m,
    input  wire shifter_pkg::word_t   rdata_s,
    output shifter_pkg::issue_t       issue
);

    logic                   accept;
    logic                   d_valid;
    shifter_pkg::instr_u    d_instr;
    shifter_pkg::word_t     d_pc;
    shifter_pkg::word_t     pc_cnt;
    shifter_pkg::word_t     pc_plus8;
    shifter_pkg::dp_reg_t   r_view;
    shifter_pkg::dp_imm_t   i_view;
    shifter_pkg::reg_addr_t rs_addr;
    shifter_pkg::word_t     val_m;
    shifter_pkg::word_t     val_s;

    // r15 first, then the execute result in flight, then the stored value
    function automatic shifter_pkg::word_t read_src(
        input shifter_pkg::reg_addr_t addr,
        input shifter_pkg::word_t     rdata,
        input shifter_pkg::word_t     pc_val,
        input shifter_pkg::result_t   bypass
    );
        shifter_pkg::word_t val;
        if (addr == `SHP_PC_REG) begin
            val = pc_val;
        end else if (bypass.valid && (bypass.rd == addr)) begin
            val = bypass.value;
        end else begin
            val = rdata;
        end
        return val;
    endfunction

    //////////////////////////////
    // instruction latch

    // other op values are dropped here and never reach the counter
    assign accept = instr_valid && (instr.dp_reg.op == `SHP_OP_DP);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            d_valid <= 1'b0;
            pc_cnt  <= '0;
        end else begin
            d_valid <= accept;
            if (accept) begin
                pc_cnt <= pc_cnt + `SHP_PC_STEP;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            d_instr <= instr;
            d_pc    <= pc_cnt;
        end
    end

    //////////////////////////////
    // operand reads

    assign r_view   = d_instr.dp_reg;
    assign i_view   = d_instr.dp_imm;
    assign pc_plus8 = d_pc + `SHP_PC_READ_OFFSET;
    assign rs_addr  = r_view.shamt5[4:1];

    // keep r15 away from the stored array
    assign ra_m = (r_view.rm == `SHP_PC_REG) ? '0 : r_view.rm;
    assign ra_s = (rs_addr == `SHP_PC_REG) ? '0 : rs_addr;

    assign val_m = read_src(r_view.rm, rdata_m, pc_plus8, fwd);
    assign val_s = read_src(rs_addr, rdata_s, pc_plus8, fwd);

    // issue bundle, view picked by the imm flag
    always_comb begin
        issue.valid = d_valid;
        issue.rd    = r_view.rd;
        if (r_view.imm) begin
            if (i_view.size) begin
                issue.operand = {{(`SHP_DATA_W-12){1'b0}}, i_view.imm12};
            end else begin
                issue.operand = {{(`SHP_DATA_W-8){1'b0}}, i_view.imm12[7:0]};
            end
            issue.amount   = '0;
            issue.kind     = shifter_pkg::lsl;
            issue.no_shift = 1'b1;
        end else begin
            issue.operand = val_m;
            if (r_view.reg_amt) begin
                issue.amount = val_s[`SHP_AMOUNT_W-1:0];
            end else begin
                issue.amount = {{(`SHP_AMOUNT_W-5){1'b0}}, r_view.shamt5};
            end
            issue.kind     = r_view.kind;
            issue.no_shift = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/shift_execute.sv */
`timescale 1ns/1ns
`default_nettype none
`include "shifter_cfg.svh"

module shift_execute (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire shifter_pkg::issue_t issue,
    output shifter_pkg::result_t     fwd,
    output shifter_pkg::result_t     wb
);

    localparam int SHIFT_W = $clog2(`SHP_DATA_W);

    logic                   e_valid;
    shifter_pkg::issue_t    e_item;
    shifter_pkg::word_t     shifted;
    logic                   wb_valid;
    shifter_pkg::reg_addr_t wb_rd;
    shifter_pkg::word_t     wb_value;

    // barrel shifter, amounts of 32 and up saturate except for ror
    function automatic shifter_pkg::word_t barrel(
        input shifter_pkg::word_t       operand,
        input logic [`SHP_AMOUNT_W-1:0] amount,
        input shifter_pkg::shift_kind_e kind
    );
        logic [2*`SHP_DATA_W-1:0] doubled;
        logic [SHIFT_W-1:0]       n;
        logic                     big;
        shifter_pkg::word_t       res;
        n       = amount[SHIFT_W-1:0];
        big     = |amount[`SHP_AMOUNT_W-1:SHIFT_W];
        doubled = {operand, operand} >> n;
        res     = operand;
        case (kind)
            shifter_pkg::lsl: begin
                res = big ? '0 : (operand << n);
            end
            shifter_pkg::lsr: begin
                res = big ? '0 : (operand >> n);
            end
            shifter_pkg::asr: begin
                // sign fill
                if (big) begin
                    res = {`SHP_DATA_W{operand[`SHP_DATA_W-1]}};
                end else begin
                    res = $signed(operand) >>> n;
                end
            end
            shifter_pkg::ror: begin
                // modulo 32 through the doubled word
                res = doubled[`SHP_DATA_W-1:0];
            end
            default: begin
                res = operand;
            end
        endcase
        return res;
    endfunction

    //////////////////////////////
    // execute register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            e_valid <= 1'b0;
        end else begin
            e_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        e_item <= issue;
    end

    // immediates bypass the shifter
    assign shifted = e_item.no_shift ? e_item.operand
                                     : barrel(e_item.operand, e_item.amount, e_item.kind);

    // combinational result for decode forwarding
    assign fwd = '{valid: e_valid, rd: e_item.rd, value: shifted};

    //////////////////////////////
    // write-back register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= e_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd    <= e_item.rd;
        wb_value <= shifted;
    end

    assign wb = '{valid: wb_valid, rd: wb_rd, value: wb_value};

endmodule

`default_nettype wire

/* hdl/shifter_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

module shifter_pipe (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                instr_valid,
    input  wire shifter_pkg::instr_u instr,
    output shifter_pkg::result_t     result
);

    shifter_pkg::reg_addr_t ra_m;
    shifter_pkg::reg_addr_t ra_s;
    shifter_pkg::word_t     rdata_m;
    shifter_pkg::word_t     rdata_s;
    shifter_pkg::issue_t    issue;
    shifter_pkg::result_t   fwd;
    shifter_pkg::result_t   wb;

    // decode, operand gather and forwarding
    operand_decode i_operand_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .fwd         (fwd),
        .ra_m        (ra_m),
        .ra_s        (ra_s),
        .rdata_m     (rdata_m),
        .rdata_s     (rdata_s),
        .issue       (issue)
    );

    // r0 to r14
    reg_file i_reg_file (
        .clk     (clk),
        .reset   (reset),
        .ra_m    (ra_m),
        .ra_s    (ra_s),
        .rdata_m (rdata_m),
        .rdata_s (rdata_s),
        .wb      (wb)
    );

    // shift and write back
    shift_execute i_shift_execute (
        .clk   (clk),
        .reset (reset),
        .issue (issue),
        .fwd   (fwd),
        .wb    (wb)
    );

    assign result = wb;

endmodule

`default_nettype wire

/* test/shifter_pipe_assertions.sv */
`timescale 1ns/1ns
`default_nettype none
`include "shifter_cfg.svh"

module shifter_pipe_assertions (
    input wire logic                 clk,
    input wire logic                 reset,
    input wire logic                 instr_valid,
    input wire shifter_pkg::instr_u  instr,
    input wire shifter_pkg::result_t result
);

    logic dp_strobe;

    assign dp_strobe = instr_valid && (instr.dp_reg.op == `SHP_OP_DP);

    // result is registered at the second edge after the strobe edge
    // and so is sampled high at the third
    result_follows_strobe: assert property (
        @(posedge clk) disable iff (reset) dp_strobe |-> ##3 result.valid
    ) else $error("result.valid missing after a data-processing strobe");

    // no result without a strobe three samples back
    result_has_cause: assert property (
        @(posedge clk) disable iff (reset) result.valid |-> $past(dp_strobe, 3)
    ) else $error("result.valid high without a matching strobe");

    result_known: assert property (
        @(posedge clk) disable iff (reset) result.valid |-> !$isunknown(result)
    ) else $error("result fields unknown while valid");

endmodule

`default_nettype wire

/* test/shifter_pipe_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "shifter_cfg.svh"

module shifter_pipe_tb;

    typedef struct packed {
        shifter_pkg::instr_u    instr;
        logic                   exp;
        shifter_pkg::reg_addr_t rd;
        shifter_pkg::word_t     value;
        logic                   b2b;
    } entry_t;

    logic                 clk;
    logic                 reset;
    logic                 instr_valid;
    shifter_pkg::instr_u  instr;
    shifter_pkg::result_t result;

    entry_t table_q[$];
    entry_t pending[$];
    int     error_count;
    int     seed;

    shifter_pipe i_shifter_pipe (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .result      (result)
    );

    bind shifter_pipe shifter_pipe_assertions i_assertions (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // instruction encoders

    function automatic shifter_pkg::instr_u enc_imm(input logic [1:0] op, input int rd,
                                                    input logic size, input logic [11:0] imm);
        shifter_pkg::dp_imm_t f;
        shifter_pkg::instr_u  u;
        f       = '0;
        f.op    = op;
        f.imm   = 1'b1;
        f.size  = size;
        f.rd    = 4'(rd);
        f.imm12 = imm;
        u.dp_imm = f;
        return u;
    endfunction

    function automatic shifter_pkg::instr_u enc_sh(input int rd, input int rm,
                                                   input shifter_pkg::shift_kind_e kind,
                                                   input int shamt);
        shifter_pkg::dp_reg_t f;
        shifter_pkg::instr_u  u;
        f        = '0;
        f.op     = `SHP_OP_DP;
        f.rd     = 4'(rd);
        f.rm     = 4'(rm);
        f.kind   = kind;
        f.shamt5 = 5'(shamt);
        u.dp_reg = f;
        return u;
    endfunction

    // amount from the low byte of rs
    function automatic shifter_pkg::instr_u enc_rs(input int rd, input int rm,
                                                   input shifter_pkg::shift_kind_e kind,
                                                   input int rs);
        shifter_pkg::instr_u u;
        u = enc_sh(rd, rm, kind, rs * 2);
        u.dp_reg.reg_amt = 1'b1;
        return u;
    endfunction

    task automatic add(input shifter_pkg::instr_u i, input logic exp, input int rd,
                       input logic [31:0] value, input logic b2b);
        entry_t e;
        e.instr = i;
        e.exp   = exp;
        e.rd    = 4'(rd);
        e.value = value;
        e.b2b   = b2b;
        table_q.push_back(e);
    endtask

    //////////////////////////////
    // compare tasks

    task automatic check_word(input string name, input shifter_pkg::word_t got,
                              input shifter_pkg::word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(input string name, input shifter_pkg::reg_addr_t got,
                              input shifter_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            if (exp) begin
                $display("t=%0t an expected result did not appear on result", $time);
            end else begin
                $display("t=%0t a result appeared where none was expected", $time);
            end
            error_count++;
        end
    endtask

    // one falling edge that checks the oldest pending item and drives the next
    task automatic step(input logic valid, input entry_t e);
        entry_t p;
        @(negedge clk);
        if (pending.size() == 3) begin
            p = pending.pop_front();
            check_valid(result.valid, p.exp);
            if (p.exp && result.valid) begin
                check_addr("result.rd", result.rd, p.rd);
                check_word("result.value", result.value, p.value);
            end
        end
        instr_valid = valid;
        instr       = e.instr;
        if (!valid) begin
            e.exp = 1'b0;
        end
        pending.push_back(e);
    endtask

    //////////////////////////////
    // stimulus table

    task automatic build_table();
        // reset values and immediates
        add(enc_sh(1, 0, shifter_pkg::lsl, 0), 1'b1, 1, 32'h0, 1'b0);
        add(enc_imm(`SHP_OP_DP, 2, 1'b0, 12'hfab), 1'b1, 2, 32'h0000_00ab, 1'b0);
        add(enc_imm(`SHP_OP_DP, 3, 1'b1, 12'hfab), 1'b1, 3, 32'h0000_0fab, 1'b0);
        add(enc_imm(`SHP_OP_DP, 4, 1'b0, 12'h080), 1'b1, 4, 32'h0000_0080, 1'b0);
        // immediate shift amounts
        add(enc_sh(5, 4, shifter_pkg::lsl, 24), 1'b1, 5, 32'h8000_0000, 1'b0);
        add(enc_sh(6, 5, shifter_pkg::asr, 4), 1'b1, 6, 32'hf800_0000, 1'b0);
        add(enc_sh(7, 5, shifter_pkg::lsr, 4), 1'b1, 7, 32'h0800_0000, 1'b0);
        add(enc_sh(8, 3, shifter_pkg::ror, 8), 1'b1, 8, 32'hab00_000f, 1'b0);
        add(enc_sh(10, 3, shifter_pkg::ror, 4), 1'b1, 10, 32'hb000_00fa, 1'b0);
        add(enc_sh(11, 10, shifter_pkg::lsl, 4), 1'b1, 11, 32'h0000_0fa0, 1'b0);
        add(enc_sh(12, 10, shifter_pkg::asr, 8), 1'b1, 12, 32'hffb0_0000, 1'b0);
        add(enc_sh(13, 10, shifter_pkg::lsr, 8), 1'b1, 13, 32'h00b0_0000, 1'b0);
        add(enc_sh(14, 10, shifter_pkg::ror, 31), 1'b1, 14, 32'h6000_01f5, 1'b0);
        // register shift amounts of 0, 4, 32 and 40
        add(enc_imm(`SHP_OP_DP, 2, 1'b0, 12'h004), 1'b1, 2, 32'h4, 1'b0);
        add(enc_imm(`SHP_OP_DP, 3, 1'b0, 12'h020), 1'b1, 3, 32'h20, 1'b0);
        add(enc_imm(`SHP_OP_DP, 4, 1'b0, 12'h028), 1'b1, 4, 32'h28, 1'b0);
        add(enc_rs(5, 10, shifter_pkg::lsl, 0), 1'b1, 5, 32'hb000_00fa, 1'b0);
        add(enc_rs(5, 10, shifter_pkg::lsl, 2), 1'b1, 5, 32'h0000_0fa0, 1'b0);
        add(enc_rs(6, 10, shifter_pkg::lsl, 3), 1'b1, 6, 32'h0, 1'b0);
        add(enc_rs(6, 10, shifter_pkg::lsr, 4), 1'b1, 6, 32'h0, 1'b0);
        add(enc_rs(7, 10, shifter_pkg::asr, 3), 1'b1, 7, 32'hffff_ffff, 1'b0);
        add(enc_rs(7, 10, shifter_pkg::asr, 2), 1'b1, 7, 32'hfb00_000f, 1'b0);
        add(enc_rs(8, 10, shifter_pkg::ror, 3), 1'b1, 8, 32'hb000_00fa, 1'b0);
        add(enc_rs(8, 10, shifter_pkg::ror, 4), 1'b1, 8, 32'hfab0_0000, 1'b0);
        add(enc_rs(9, 10, shifter_pkg::lsr, 2), 1'b1, 9, 32'h0b00_000f, 1'b0);
        // dependent chain with no gaps
        add(enc_imm(`SHP_OP_DP, 1, 1'b1, 12'h123), 1'b1, 1, 32'h123, 1'b1);
        add(enc_sh(1, 1, shifter_pkg::lsl, 4), 1'b1, 1, 32'h1230, 1'b1);
        add(enc_sh(2, 1, shifter_pkg::lsl, 4), 1'b1, 2, 32'h0001_2300, 1'b1);
        add(enc_sh(3, 2, shifter_pkg::ror, 8), 1'b1, 3, 32'h123, 1'b1);
        add(enc_sh(4, 3, shifter_pkg::asr, 0), 1'b1, 4, 32'h123, 1'b1);
        add(enc_imm(`SHP_OP_DP, 6, 1'b0, 12'h003), 1'b1, 6, 32'h3, 1'b1);
        add(enc_rs(7, 1, shifter_pkg::lsl, 6), 1'b1, 7, 32'h9180, 1'b0);
        // r15 reads as address plus 8
        add(enc_sh(8, 15, shifter_pkg::lsl, 0), 1'b1, 8, 32'd136, 1'b0);
        add(enc_imm(`SHP_OP_DP, 15, 1'b0, 12'h055), 1'b1, 15, 32'h55, 1'b1);
        add(enc_sh(9, 15, shifter_pkg::lsl, 0), 1'b1, 9, 32'd144, 1'b0);
        // other op values are ignored
        add(enc_imm(2'b01, 9, 1'b0, 12'h0ee), 1'b0, 0, 32'h0, 1'b1);
        add(enc_imm(2'b11, 1, 1'b1, 12'h777), 1'b0, 0, 32'h0, 1'b0);
        add(enc_sh(10, 15, shifter_pkg::lsl, 0), 1'b1, 10, 32'd148, 1'b0);
        add(enc_sh(11, 9, shifter_pkg::lsl, 0), 1'b1, 11, 32'd144, 1'b0);
        add(enc_sh(12, 1, shifter_pkg::lsl, 0), 1'b1, 12, 32'h1230, 1'b0);
    endtask

    //////////////////////////////
    // main sequence

    initial begin
        entry_t idle;
        int     gap;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        error_count = 0;
        seed        = 32'h85353fc7;
        idle        = '0;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // three idle slots check that nothing comes out of reset
        pending.push_back(idle);
        pending.push_back(idle);
        pending.push_back(idle);
        foreach (table_q[i]) begin
            step(1'b1, table_q[i]);
            gap = int'($unsigned($random(seed)) % 3);
            if (table_q[i].b2b) begin
                gap = 0;
            end
            repeat (gap) step(1'b0, idle);
        end
        repeat (3) step(1'b0, idle);
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog scaled to the table length
    initial begin
        int limit;
        #1;
        limit = table_q.size() * 5 * 4 + 8 * 4 + 200;
        #(limit);
        $display("watchdog expired before the stimulus table finished");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hdl
hdl/shifter_pkg.sv
hdl/reg_file.sv
hdl/operand_decode.sv
hdl/shift_execute.sv
hdl/shifter_pipe.sv
test/shifter_pipe_assertions.sv
test/shifter_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the shifter pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f flist.f \
    --top-module shifter_pipe_tb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vshifter_pipe_tb > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "All tests passed!" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
